// File: hw/clock_pkg.sv
package clock_pkg;

	// ----------------------------------------
	// widths with a meaning
	// ----------------------------------------
	typedef logic [6:0] field_val_t;	// one two-digit field, 0..99
	typedef logic [3:0] digit_t;		// one decimal digit
	typedef logic [6:0] seg_t;			// a..g from msb down, active high
	typedef logic [5:0] digit_sel_t;	// active-low digit enables

	localparam int CSEC_PER_SEC = 100;
	localparam int N_DIGITS = 6;

	// ----------------------------------------
	// state machines
	// ----------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK,
		MODE_SETUP,
		MODE_ALARM,
		MODE_STOPW
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HR
	} field_t;

	// ----------------------------------------
	// bundles between blocks
	// ----------------------------------------
	typedef struct packed {
		field_val_t hr;
		field_val_t min;
		field_val_t sec;
	} hms_t;

	typedef struct packed {
		field_val_t min;
		field_val_t sec;
		field_val_t csec;
	} sw_time_t;

	// one bit per panel button
	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm;
		logic sw_run;
		logic sw_clr;
	} btn_t;

	typedef struct packed {
		logic csec;
		logic sec;
		logic scan;
	} tick_t;

	typedef struct packed {
		mode_t  mode;
		field_t pos;
		logic   inc;		// pulse
		logic   alarm_en;	// level
		logic   sw_run;		// level
		logic   sw_clr;		// pulse
	} ctrl_t;

endpackage

// File: hw/wrap_cnt.sv
`timescale 1ns/1ps

module wrap_cnt import clock_pkg::*; #(
	parameter int MAX = 59
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_clr,
	input  logic       i_inc,
	output field_val_t o_val,
	output logic       o_wrap
);

	logic at_max;

	assign at_max = (o_val == field_val_t'(MAX));
	assign o_wrap = i_inc && at_max;	// carry to the next field

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_val <= '0;
		end else if (i_clr) begin
			o_val <= '0;
		end else if (i_inc) begin
			o_val <= at_max ? '0 : o_val + 1'b1;
		end
	end

	a_val_range: assert property (@(posedge clk) disable iff (!rst_n) o_val <= MAX);

endmodule

// File: hw/tick_gen.sv
`timescale 1ns/1ps

module tick_gen import clock_pkg::*; #(
	parameter int CLK_PER_CSEC = 500000,
	parameter int CLK_PER_SCAN = 2500
) (
	input  logic  clk,
	input  logic  rst_n,
	output tick_t o_tick
);

	localparam int CW = $clog2(CLK_PER_CSEC + 1);
	localparam int SW = $clog2(CLK_PER_SCAN + 1);

	logic [CW-1:0] csec_cnt;
	logic [SW-1:0] scan_cnt;
	field_val_t    sec_cnt;	// csec ticks within the second
	logic          csec_hit;
	logic          sec_hit;
	logic          scan_hit;

	assign csec_hit = (csec_cnt == CW'(CLK_PER_CSEC - 1));
	assign scan_hit = (scan_cnt == SW'(CLK_PER_SCAN - 1));
	assign sec_hit  = csec_hit && (sec_cnt == field_val_t'(CSEC_PER_SEC - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csec_cnt <= '0;
			sec_cnt  <= '0;
			scan_cnt <= '0;
		end else begin
			csec_cnt <= csec_hit ? '0 : csec_cnt + 1'b1;
			scan_cnt <= scan_hit ? '0 : scan_cnt + 1'b1;
			if (csec_hit)
				sec_cnt <= sec_hit ? '0 : sec_cnt + 1'b1;
		end
	end

	assign o_tick = '{csec: csec_hit, sec: sec_hit, scan: scan_hit};

endmodule

// File: hw/panel_ctrl.sv
`timescale 1ns/1ps

module panel_ctrl import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  btn_t  i_btn_n,
	output ctrl_t o_ctrl
);

	btn_t   sync1_q;
	btn_t   sync2_q;
	btn_t   prev_q;
	btn_t   fall;		// one-cycle press per button
	mode_t  mode_q;
	field_t pos_q;
	logic   inc_q;
	logic   alarm_en_q;
	logic   sw_run_q;
	logic   sw_clr_q;

	function automatic mode_t next_mode(input mode_t m);
		case (m)
			MODE_CLOCK: next_mode = MODE_SETUP;
			MODE_SETUP: next_mode = MODE_ALARM;
			MODE_ALARM: next_mode = MODE_STOPW;
			default:    next_mode = MODE_CLOCK;
		endcase
	endfunction

	function automatic field_t next_pos(input field_t p);
		case (p)
			POS_SEC: next_pos = POS_MIN;
			POS_MIN: next_pos = POS_HR;
			default: next_pos = POS_SEC;
		endcase
	endfunction

	// ----------------------------------------
	// synchronizer and edge detect
	// ----------------------------------------
	// all flops start low, so a button held through reset gives no press
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
		end else begin
			sync1_q <= i_btn_n;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
		end
	end

	assign fall = prev_q & ~sync2_q;	// high-to-low

	// ----------------------------------------
	// mode, field and toggles
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			inc_q      <= 1'b0;
			alarm_en_q <= 1'b0;
			sw_run_q   <= 1'b0;
			sw_clr_q   <= 1'b0;
		end else begin
			if (fall.mode)
				mode_q <= next_mode(mode_q);
			if (fall.pos)
				pos_q <= next_pos(pos_q);
			if (fall.alarm)
				alarm_en_q <= ~alarm_en_q;
			if (fall.sw_run)
				sw_run_q <= ~sw_run_q;
			inc_q    <= fall.inc;
			sw_clr_q <= fall.sw_clr;
		end
	end

	assign o_ctrl = '{
		mode:     mode_q,
		pos:      pos_q,
		inc:      inc_q,
		alarm_en: alarm_en_q,
		sw_run:   sw_run_q,
		sw_clr:   sw_clr_q
	};

	a_inc_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		o_ctrl.inc |=> !o_ctrl.inc);
	a_clr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		o_ctrl.sw_clr |=> !o_ctrl.sw_clr);

endmodule

// File: hw/time_keeper.sv
`timescale 1ns/1ps

module time_keeper import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  tick_t i_tick,
	input  ctrl_t i_ctrl,
	output hms_t  o_time,
	output hms_t  o_alarm_time,
	output logic  o_alarm
);

	logic run;			// time advances outside setup
	logic set_inc;
	logic alm_inc;
	logic sec_wrap;
	logic min_wrap;
	logic t_sec_inc;
	logic t_min_inc;
	logic t_hr_inc;

	assign run     = (i_ctrl.mode != MODE_SETUP);
	assign set_inc = (i_ctrl.mode == MODE_SETUP) && i_ctrl.inc;
	assign alm_inc = (i_ctrl.mode == MODE_ALARM) && i_ctrl.inc;

	// carry chain while running, selected field only in setup
	assign t_sec_inc = run ? i_tick.sec : set_inc && (i_ctrl.pos == POS_SEC);
	assign t_min_inc = run ? sec_wrap   : set_inc && (i_ctrl.pos == POS_MIN);
	assign t_hr_inc  = run ? min_wrap   : set_inc && (i_ctrl.pos == POS_HR);

	// ----------------------------------------
	// time of day
	// ----------------------------------------
	wrap_cnt #(.MAX(59)) u_sec (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (1'b0),
		.i_inc  (t_sec_inc),
		.o_val  (o_time.sec),
		.o_wrap (sec_wrap)
	);

	wrap_cnt #(.MAX(59)) u_min (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (1'b0),
		.i_inc  (t_min_inc),
		.o_val  (o_time.min),
		.o_wrap (min_wrap)
	);

	wrap_cnt #(.MAX(23)) u_hr (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (1'b0),
		.i_inc  (t_hr_inc),
		.o_val  (o_time.hr),
		.o_wrap ()				// day rolls over silently
	);

	// ----------------------------------------
	// alarm time, no carry between fields
	// ----------------------------------------
	wrap_cnt #(.MAX(59)) u_alm_sec (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (1'b0),
		.i_inc  (alm_inc && (i_ctrl.pos == POS_SEC)),
		.o_val  (o_alarm_time.sec),
		.o_wrap ()
	);

	wrap_cnt #(.MAX(59)) u_alm_min (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (1'b0),
		.i_inc  (alm_inc && (i_ctrl.pos == POS_MIN)),
		.o_val  (o_alarm_time.min),
		.o_wrap ()
	);

	wrap_cnt #(.MAX(23)) u_alm_hr (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (1'b0),
		.i_inc  (alm_inc && (i_ctrl.pos == POS_HR)),
		.o_val  (o_alarm_time.hr),
		.o_wrap ()
	);

	// sticky until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else if (!i_ctrl.alarm_en)
			o_alarm <= 1'b0;
		else if (o_time == o_alarm_time)
			o_alarm <= 1'b1;
	end

	a_alarm_off: assert property (@(posedge clk) disable iff (!rst_n)
		!i_ctrl.alarm_en |=> !o_alarm);

endmodule

// File: hw/stopwatch.sv
`timescale 1ns/1ps

module stopwatch import clock_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  tick_t    i_tick,
	input  ctrl_t    i_ctrl,
	output sw_time_t o_sw
);

	logic csec_wrap;
	logic sec_wrap;

	wrap_cnt #(.MAX(99)) u_csec (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (i_ctrl.sw_clr),
		.i_inc  (i_ctrl.sw_run && i_tick.csec),
		.o_val  (o_sw.csec),
		.o_wrap (csec_wrap)
	);

	wrap_cnt #(.MAX(59)) u_sec (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (i_ctrl.sw_clr),
		.i_inc  (csec_wrap),
		.o_val  (o_sw.sec),
		.o_wrap (sec_wrap)
	);

	// minutes roll back to zero after 59
	wrap_cnt #(.MAX(59)) u_min (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_clr  (i_ctrl.sw_clr),
		.i_inc  (sec_wrap),
		.o_val  (o_sw.min),
		.o_wrap ()
	);

endmodule

// File: hw/display_scan.sv
`timescale 1ns/1ps

module display_scan import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  tick_t      i_tick,
	input  ctrl_t      i_ctrl,
	input  hms_t       i_time,
	input  hms_t       i_alarm_time,
	input  sw_time_t   i_sw,
	output seg_t       o_seg,
	output digit_sel_t o_seg_enb
);

	logic [2:0] idx_q;		// digit being driven
	logic [2:0] idx_nxt;
	hms_t       shown;
	field_val_t fld;
	digit_t     dig;

	function automatic seg_t seg_decode(input digit_t d);
		case (d)
			4'd0:    seg_decode = 7'b111_1110;
			4'd1:    seg_decode = 7'b011_0000;
			4'd2:    seg_decode = 7'b110_1101;
			4'd3:    seg_decode = 7'b111_1001;
			4'd4:    seg_decode = 7'b011_0011;
			4'd5:    seg_decode = 7'b101_1011;
			4'd6:    seg_decode = 7'b101_1111;
			4'd7:    seg_decode = 7'b111_0000;
			4'd8:    seg_decode = 7'b111_1111;
			4'd9:    seg_decode = 7'b111_1011;
			default: seg_decode = 7'b000_0000;	// blank
		endcase
	endfunction

	// ----------------------------------------
	// content by mode
	// ----------------------------------------
	always_comb begin
		case (i_ctrl.mode)
			MODE_ALARM: shown = i_alarm_time;
			MODE_STOPW: shown = '{hr: i_sw.min, min: i_sw.sec, sec: i_sw.csec};
			default:    shown = i_time;		// clock and setup
		endcase
	end

	// ----------------------------------------
	// scan position and digit split
	// ----------------------------------------
	always_comb begin
		if (!i_tick.scan)
			idx_nxt = idx_q;
		else if (idx_q == 3'(N_DIGITS - 1))
			idx_nxt = 3'd0;
		else
			idx_nxt = idx_q + 3'd1;
	end

	always_comb begin
		case (idx_nxt[2:1])
			2'd0:    fld = shown.sec;
			2'd1:    fld = shown.min;
			default: fld = shown.hr;
		endcase
	end

	// odd digits carry the tens
	assign dig = idx_nxt[0] ? digit_t'(fld / 7'd10) : digit_t'(fld % 7'd10);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q     <= 3'd0;
			o_seg_enb <= ~digit_sel_t'(1);
			o_seg     <= '0;
		end else begin
			idx_q     <= idx_nxt;
			o_seg_enb <= ~(digit_sel_t'(1) << idx_nxt);
			o_seg     <= seg_decode(dig);	// same cycle as the enable
		end
	end

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

// File: hw/digital_clock_top.sv
`timescale 1ns/1ps

module digital_clock_top import clock_pkg::*; #(
	parameter int CLK_PER_CSEC = 500000,	// 100 Hz at 50 MHz
	parameter int CLK_PER_SCAN = 2500
) (
	input  logic       clk,
	input  logic       rst_n,
	input  btn_t       i_btn_n,
	output seg_t       o_seg,
	output digit_sel_t o_seg_enb,
	output logic       o_alarm
);

	tick_t    tick;
	ctrl_t    ctrl;
	hms_t     time_hms;
	hms_t     alarm_hms;
	sw_time_t sw_time;

	tick_gen #(
		.CLK_PER_CSEC (CLK_PER_CSEC),
		.CLK_PER_SCAN (CLK_PER_SCAN)
	) u_tick_gen (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (tick)
	);

	panel_ctrl u_panel_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_btn_n (i_btn_n),
		.o_ctrl  (ctrl)
	);

	time_keeper u_time_keeper (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_tick       (tick),
		.i_ctrl       (ctrl),
		.o_time       (time_hms),
		.o_alarm_time (alarm_hms),
		.o_alarm      (o_alarm)
	);

	stopwatch u_stopwatch (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (tick),
		.i_ctrl (ctrl),
		.o_sw   (sw_time)
	);

	display_scan u_display_scan (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_tick       (tick),
		.i_ctrl       (ctrl),
		.i_time       (time_hms),
		.i_alarm_time (alarm_hms),
		.i_sw         (sw_time),
		.o_seg        (o_seg),
		.o_seg_enb    (o_seg_enb)
	);

endmodule

// File: dv/tb_digital_clock.sv
`timescale 1ns/1ps

module tb_digital_clock import clock_pkg::*; ();

	localparam int CLK_PER_CSEC = 4;
	localparam int CLK_PER_SCAN = 2;
	localparam int CYC_PER_SEC  = CLK_PER_CSEC * CSEC_PER_SEC;	// 400 cycles
	localparam int CYCLE_LIMIT  = 30000;	// ~25 s of 400 cycles plus presses, with margin

	// one set bit per button, in btn_t order
	localparam btn_t PRESS_MODE   = 6'b100000;
	localparam btn_t PRESS_POS    = 6'b010000;
	localparam btn_t PRESS_INC    = 6'b001000;
	localparam btn_t PRESS_ALARM  = 6'b000100;
	localparam btn_t PRESS_SW_RUN = 6'b000010;
	localparam btn_t PRESS_SW_CLR = 6'b000001;

	typedef logic [N_DIGITS-1:0][6:0] panel_t;	// segments per digit position

	logic       clk;
	logic       rst_n;
	btn_t       btn_n;
	seg_t       seg;
	digit_sel_t seg_enb;
	logic       alarm;

	int    cyc;			// rising edges since reset release
	int    seed;
	int    n_checks;
	int    n_errors;
	int    press_cyc;	// cycle at which the last button went low
	mode_t m_mode;
	hms_t  m_time;
	hms_t  m_alarm;

	digital_clock_top #(
		.CLK_PER_CSEC (CLK_PER_CSEC),
		.CLK_PER_SCAN (CLK_PER_SCAN)
	) i_digital_clock_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_btn_n   (btn_n),
		.o_seg     (seg),
		.o_seg_enb (seg_enb),
		.o_alarm   (alarm)
	);

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic seg_t digit_segments(input digit_t d);
		case (d)
			4'd0:    digit_segments = 7'b1111110;	// abcdef
			4'd1:    digit_segments = 7'b0110000;	// bc
			4'd2:    digit_segments = 7'b1101101;	// abdeg
			4'd3:    digit_segments = 7'b1111001;	// abcdg
			4'd4:    digit_segments = 7'b0110011;	// bcfg
			4'd5:    digit_segments = 7'b1011011;	// acdfg
			4'd6:    digit_segments = 7'b1011111;	// acdefg
			4'd7:    digit_segments = 7'b1110000;	// abc
			4'd8:    digit_segments = 7'b1111111;
			4'd9:    digit_segments = 7'b1111011;	// abcdfg
			default: digit_segments = 7'b0000000;
		endcase
	endfunction

	// digit 0 is the seconds ones, digit 5 the hours tens
	function automatic panel_t panel_for(input hms_t t);
		panel_t p;
		p[0] = digit_segments(digit_t'(t.sec % 7'd10));
		p[1] = digit_segments(digit_t'(t.sec / 7'd10));
		p[2] = digit_segments(digit_t'(t.min % 7'd10));
		p[3] = digit_segments(digit_t'(t.min / 7'd10));
		p[4] = digit_segments(digit_t'(t.hr % 7'd10));
		p[5] = digit_segments(digit_t'(t.hr / 7'd10));
		return p;
	endfunction

	function automatic hms_t add_second(input hms_t t);
		hms_t r;
		r = t;
		if (r.sec == 7'd59) begin
			r.sec = 7'd0;
			if (r.min == 7'd59) begin
				r.min = 7'd0;
				r.hr  = (r.hr == 7'd23) ? 7'd0 : r.hr + 7'd1;
			end else begin
				r.min = r.min + 7'd1;
			end
		end else begin
			r.sec = r.sec + 7'd1;
		end
		return r;
	endfunction

	// n increments on one field, wrap without carry
	function automatic hms_t bump_field(input hms_t t, input field_t f, input int n);
		hms_t r;
		r = t;
		case (f)
			POS_SEC: r.sec = field_val_t'((int'(t.sec) + n) % 60);
			POS_MIN: r.min = field_val_t'((int'(t.min) + n) % 60);
			default: r.hr  = field_val_t'((int'(t.hr) + n) % 24);
		endcase
		return r;
	endfunction

	// stopwatch count in hr, min, sec places
	function automatic hms_t sw_panel(input int n);
		hms_t r;
		r.hr  = field_val_t'((n / 6000) % 60);
		r.min = field_val_t'((n / 100) % 60);
		r.sec = field_val_t'(n % 100);
		return r;
	endfunction

	// ----------------------------------------
	// stimulus and check helpers
	// ----------------------------------------
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	// keeps clear of a second boundary so mode changes never race a tick
	task automatic press(input btn_t b);
		step();
		while (cyc % CYC_PER_SEC >= CYC_PER_SEC - 20)
			step();
		btn_n     = ~b;
		press_cyc = cyc;
		repeat (4) step();
		btn_n = '1;
		repeat (4) step();
	endtask

	task automatic wait_mid();
		do
			step();
		while (cyc % CYC_PER_SEC != CYC_PER_SEC / 2);
	endtask

	task automatic wait_sec_mid(input field_val_t s);
		do
			step();
		while (!(m_time.sec == s && cyc % CYC_PER_SEC == CYC_PER_SEC / 2));
	endtask

	task automatic capture_panel(output panel_t p);
		logic [N_DIGITS-1:0] seen;
		seen = '0;
		p    = '0;
		repeat (2 * N_DIGITS) begin
			@(negedge clk);
			for (int k = 0; k < N_DIGITS; k++) begin
				if (seg_enb[k] === 1'b0) begin
					p[k]    = seg;
					seen[k] = 1'b1;
				end
			end
		end
		n_checks++;
		if (seen !== '1) begin
			n_errors++;
			$display("** Error at %0t: not every digit was scanned within 12 cycles (seen %b)",
				$time, seen);
		end
	endtask

	task automatic compare_panel(input panel_t exp, input panel_t got, input string what);
		for (int k = 0; k < N_DIGITS; k++) begin
			n_checks++;
			if (got[k] !== exp[k]) begin
				n_errors++;
				$display("** Error at %0t: o_seg digit %0d (%s) expected %b, got %b",
					$time, k, what, exp[k], got[k]);
			end
		end
	endtask

	task automatic check_alarm(input logic exp, input string what);
		n_checks++;
		if (alarm !== exp) begin
			n_errors++;
			$display("** Error at %0t: o_alarm (%s) expected %b, got %b", $time, what, exp, alarm);
		end
	endtask

	task automatic report_and_finish(input bit timed_out);
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0 && !timed_out)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	// ----------------------------------------
	// clock, model time and scan monitor
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cyc = cyc + 1;
			if (cyc >= CYCLE_LIMIT) begin
				$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
				report_and_finish(1'b1);
			end else if (cyc % CYC_PER_SEC == 0 && m_mode != MODE_SETUP) begin
				m_time = add_second(m_time);	// frozen in setup
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n && $countones(~seg_enb) != 1) begin
			n_errors++;
			$display("** Error at %0t: o_seg_enb expected one low bit, got %b", $time, seg_enb);
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		panel_t p1;
		panel_t p2;
		panel_t sw_lo;
		panel_t sw_hi;
		int     cnt;
		int     target;
		int     elapsed;

		seed      = 1214;
		rst_n     = 1'b0;
		btn_n     = '1;		// all released
		cyc       = 0;
		n_checks  = 0;
		n_errors  = 0;
		press_cyc = 0;
		m_mode    = MODE_CLOCK;
		m_time    = '0;
		m_alarm   = '0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		repeat (2) begin
			wait_mid();
			capture_panel(p1);
			compare_panel(panel_for(m_time), p1, "free-running time");
			check_alarm(1'b0, "alarm disabled");
		end

		// setup, one random count per field
		press(PRESS_MODE);
		m_mode = MODE_SETUP;
		cnt = 60 + ($random(seed) & 7);	// passes 59 -> 0
		repeat (cnt) press(PRESS_INC);
		m_time = bump_field(m_time, POS_SEC, cnt);
		press(PRESS_POS);
		cnt = 1 + ($random(seed) & 31);
		repeat (cnt) press(PRESS_INC);
		m_time = bump_field(m_time, POS_MIN, cnt);
		press(PRESS_POS);
		cnt = 1 + ($random(seed) & 31);
		repeat (cnt) press(PRESS_INC);
		m_time = bump_field(m_time, POS_HR, cnt);
		press(PRESS_POS);		// back to seconds
		capture_panel(p1);
		compare_panel(panel_for(m_time), p1, "setup");
		repeat (800) step();
		capture_panel(p2);
		compare_panel(panel_for(m_time), p2, "setup after wait");

		// alarm hr and min follow the time, sec lands a few seconds ahead
		press(PRESS_MODE);
		m_mode = MODE_ALARM;
		capture_panel(p1);
		compare_panel(panel_for(m_alarm), p1, "alarm at reset");
		press(PRESS_POS);
		cnt = m_time.min;
		repeat (cnt) press(PRESS_INC);
		m_alarm = bump_field(m_alarm, POS_MIN, cnt);
		press(PRESS_POS);
		cnt = m_time.hr;
		repeat (cnt) press(PRESS_INC);
		m_alarm = bump_field(m_alarm, POS_HR, cnt);
		press(PRESS_POS);
		target = m_time.sec + 3;
		repeat (target) press(PRESS_INC);
		m_alarm = bump_field(m_alarm, POS_SEC, target);
		capture_panel(p1);
		compare_panel(panel_for(m_alarm), p1, "alarm setting");
		press(PRESS_ALARM);	// enable on
		wait_sec_mid(field_val_t'(target - 1));
		check_alarm(1'b0, "before match");
		wait_sec_mid(field_val_t'(target));
		check_alarm(1'b1, "after match");
		press(PRESS_ALARM);
		check_alarm(1'b0, "enable off");

		// ----------------------------------------
		// stopwatch
		// ----------------------------------------
		press(PRESS_MODE);
		m_mode = MODE_STOPW;
		capture_panel(p1);
		compare_panel(panel_for('0), p1, "stopwatch at reset");
		press(PRESS_SW_RUN);
		elapsed = press_cyc;
		repeat (1000) step();
		press(PRESS_SW_RUN);
		elapsed = press_cyc - elapsed;
		capture_panel(p1);
		sw_lo = panel_for(sw_panel(elapsed / CLK_PER_CSEC));
		sw_hi = panel_for(sw_panel(elapsed / CLK_PER_CSEC + 1));	// tick phase
		n_checks++;
		if (p1 !== sw_lo && p1 !== sw_hi) begin
			n_errors++;
			$display("** Error at %0t: o_seg (stopwatch) expected %h or %h, got %h",
				$time, sw_lo, sw_hi, p1);
		end
		repeat (200) step();
		capture_panel(p2);
		n_checks++;
		if (p2 !== p1) begin
			n_errors++;
			$display("** Error at %0t: the stopped stopwatch kept counting", $time);
		end
		press(PRESS_SW_CLR);
		capture_panel(p1);
		compare_panel(panel_for('0), p1, "stopwatch cleared");

		// fourth mode press wraps to the clock
		press(PRESS_MODE);
		m_mode = MODE_CLOCK;
		wait_mid();
		capture_panel(p1);
		compare_panel(panel_for(m_time), p1, "back to clock");
		check_alarm(1'b0, "final");
		report_and_finish(1'b0);
	end

endmodule

// File: src.f
hw/clock_pkg.sv
hw/wrap_cnt.sv
hw/tick_gen.sv
hw/panel_ctrl.sv
hw/time_keeper.sv
hw/stopwatch.sv
hw/display_scan.sv
hw/digital_clock_top.sv
dv/tb_digital_clock.sv

// File: Bender.yml
package:
  name: digital_clock

sources:
  - files:
      - hw/clock_pkg.sv
      - hw/wrap_cnt.sv
      - hw/tick_gen.sv
      - hw/panel_ctrl.sv
      - hw/time_keeper.sv
      - hw/stopwatch.sv
      - hw/display_scan.sv
      - hw/digital_clock_top.sv
  - target: simulation
    files:
      - dv/tb_digital_clock.sv
